// ==== prf_exec.f ====
design/cpu_types_pkg.sv
design/exec_pkg.sv
design/physical_register_file.sv
design/int_alu_unit.sv
design/mul_div_unit.sv
design/writeback_arbiter.sv
design/prf_exec_top.sv
verification/tb_clock_gen.sv
verification/prf_exec_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the verdict.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
    --top-module prf_exec_tb -f prf_exec.f -o prf_exec_sim

./obj_dir/prf_exec_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test passed" sim.log; then
    echo "Simulation run passed."
    exit 0
fi
echo "Simulation run failed."
exit 1

// ==== verification/prf_exec_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module prf_exec_tb;

    localparam int wait_limit = 100;

    logic clk;
    logic reset;
    cpu_types_pkg::phys_reg_t alloc_dst;
    cpu_types_pkg::phys_reg_t disp_src1;
    cpu_types_pkg::phys_reg_t disp_src2;
    cpu_types_pkg::data_t disp_data1;
    cpu_types_pkg::data_t disp_data2;
    logic disp_ready1;
    logic disp_ready2;
    exec_pkg::alu_issue_t alu_issue;
    logic alu_busy;
    exec_pkg::md_issue_t md_issue;
    logic md_busy;
    exec_pkg::wb_result_t load_result;
    logic load_grant;

    // Expected register contents and valid bits.
    cpu_types_pkg::data_t exp_val [cpu_types_pkg::num_phys_regs];
    logic exp_valid [cpu_types_pkg::num_phys_regs];
    int write_count [cpu_types_pkg::num_phys_regs];

    int value_errors;
    int other_errors;
    int next_reg;
    int rr_model;
    int contended_cycles;

    tb_clock_gen clock_i (.clk(clk), .reset(reset));

    prf_exec_top dut_i (
        .clk(clk), .reset(reset),
        .alloc_dst(alloc_dst),
        .disp_src1(disp_src1), .disp_src2(disp_src2),
        .disp_data1(disp_data1), .disp_data2(disp_data2),
        .disp_ready1(disp_ready1), .disp_ready2(disp_ready2),
        .alu_issue(alu_issue), .alu_busy(alu_busy),
        .md_issue(md_issue), .md_busy(md_busy),
        .load_result(load_result), .load_grant(load_grant)
    );

    // Round-robin model of the writeback arbiter, checked every cycle.
    always @(negedge clk) begin
        logic [exec_pkg::num_wb_sources-1:0] req;
        logic [exec_pkg::num_wb_sources-1:0] exp_grant;
        int idx;
        int win;
        if (reset) begin
            rr_model = 0;
        end else begin
            req[exec_pkg::wb_src_alu] = dut_i.alu_result.valid;
            req[exec_pkg::wb_src_md] = dut_i.md_result.valid;
            req[exec_pkg::wb_src_load] = load_result.valid;
            exp_grant = '0;
            win = -1;
            for (int k = 0; k < exec_pkg::num_wb_sources; k++) begin
                idx = (rr_model + k) % exec_pkg::num_wb_sources;
                if (win < 0 && req[idx]) win = idx;
            end
            if (win >= 0) begin
                exp_grant[win] = 1'b1;
                rr_model = (win + 1) % exec_pkg::num_wb_sources; // Search starts past the winner.
            end
            if ($countones(req) > 1) contended_cycles++;
            if (dut_i.grant !== exp_grant) begin
                $display("** Error: grant = 0x%h, expected 0x%h", dut_i.grant, exp_grant);
                value_errors++;
            end
            if (dut_i.wb_bus.valid) write_count[dut_i.wb_bus.dst]++;
        end
    end

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        if (got !== expected) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, expected);
            value_errors++;
        end
    endtask

    task automatic read_and_compare(input cpu_types_pkg::phys_reg_t r);
        @(posedge clk);
        disp_src1 <= r;
        @(negedge clk);
        compare_word("disp_data1", disp_data1, exp_val[r]);
        compare_word("disp_ready1", disp_ready1, exp_valid[r]);
    endtask

    // Takes the next free register and checks that it turns not ready.
    task automatic allocate_reg(output cpu_types_pkg::phys_reg_t r);
        r = cpu_types_pkg::phys_reg_t'(next_reg);
        next_reg++;
        @(posedge clk);
        alloc_dst <= r;
        @(posedge clk);
        alloc_dst <= '0;
        exp_valid[r] = 1'b0;
        read_and_compare(r);
    endtask

    task automatic present_load(input cpu_types_pkg::phys_reg_t r, input cpu_types_pkg::data_t d);
        @(posedge clk);
        load_result <= '{valid: 1'b1, dst: r, data: d};
    endtask

    // Holds the load until it is granted, then drops it.
    task automatic finish_load();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!load_grant && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!load_grant) begin
            $display("Load result was never granted.");
            other_errors++;
        end
        @(posedge clk);
        load_result <= '0;
    endtask

    task automatic await_result(input cpu_types_pkg::phys_reg_t r, input cpu_types_pkg::data_t d);
        int cycles;
        exp_val[r] = d;
        exp_valid[r] = 1'b1;
        cycles = 0;
        @(posedge clk);
        disp_src1 <= r;
        @(negedge clk);
        while (!disp_ready1 && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!disp_ready1) begin
            $display("Register %0d did not become ready in time.", r);
            other_errors++;
        end else begin
            compare_word("disp_data1", disp_data1, exp_val[r]);
        end
    endtask

    task automatic load_value(output cpu_types_pkg::phys_reg_t r, input cpu_types_pkg::data_t d);
        allocate_reg(r);
        present_load(r, d);
        finish_load();
        await_result(r, d);
    endtask

    task automatic issue_alu(input exec_pkg::alu_op_e op, input cpu_types_pkg::phys_reg_t s1,
                             input cpu_types_pkg::phys_reg_t s2,
                             input cpu_types_pkg::phys_reg_t d);
        @(posedge clk);
        alu_issue <= '{valid: 1'b1, op: op, src1: s1, src2: s2, dst: d};
        @(posedge clk);
        alu_issue <= '0;
    endtask

    task automatic issue_md(input exec_pkg::md_op_e op, input cpu_types_pkg::phys_reg_t s1,
                            input cpu_types_pkg::phys_reg_t s2,
                            input cpu_types_pkg::phys_reg_t d);
        @(posedge clk);
        md_issue <= '{valid: 1'b1, op: op, src1: s1, src2: s2, dst: d};
        @(posedge clk);
        md_issue <= '0;
    endtask

    function automatic cpu_types_pkg::data_t alu_expect(input exec_pkg::alu_op_e op,
                                                        input cpu_types_pkg::data_t a,
                                                        input cpu_types_pkg::data_t b);
        case (op)
            exec_pkg::alu_add: return a + b;
            exec_pkg::alu_sub: return a + ~b + 32'd1;
            exec_pkg::alu_and: return a & b;
            exec_pkg::alu_or:  return a | b;
            exec_pkg::alu_xor: return a ^ b;
            default: begin
                if (a[31] != b[31]) return {31'd0, a[31]}; // Negative side is smaller.
                return {31'd0, a < b};
            end
        endcase
    endfunction

    function automatic cpu_types_pkg::data_t md_expect(input exec_pkg::md_op_e op,
                                                       input cpu_types_pkg::data_t a,
                                                       input cpu_types_pkg::data_t b);
        logic [63:0] product;
        product = {32'd0, a} * {32'd0, b};
        case (op)
            exec_pkg::md_mul:  return product[31:0];
            exec_pkg::md_divu: return (b == 0) ? 32'hffff_ffff : a / b;
            default:           return (b == 0) ? a : a % b;
        endcase
    endfunction

    task automatic check_reset_contents();
        for (int i = 0; i <= 40; i++) begin
            @(posedge clk);
            disp_src1 <= cpu_types_pkg::phys_reg_t'(i);
            disp_src2 <= cpu_types_pkg::phys_reg_t'(40 - i);
            @(negedge clk);
            compare_word("disp_data1", disp_data1, exp_val[i]);
            compare_word("disp_ready1", disp_ready1, exp_valid[i]);
            compare_word("disp_data2", disp_data2, exp_val[40 - i]);
            compare_word("disp_ready2", disp_ready2, exp_valid[40 - i]);
        end
        compare_word("alu_busy", alu_busy, 0);
        compare_word("md_busy", md_busy, 0);
        compare_word("load_grant", load_grant, 0);
    endtask

    task automatic run_alu_ops();
        cpu_types_pkg::phys_reg_t s1;
        cpu_types_pkg::phys_reg_t s2;
        cpu_types_pkg::phys_reg_t d;
        cpu_types_pkg::data_t a;
        cpu_types_pkg::data_t b;
        exec_pkg::alu_op_e op;
        for (int k = 0; k < 6; k++) begin
            op = exec_pkg::alu_op_e'(k);
            a = $urandom();
            b = $urandom();
            load_value(s1, a);
            load_value(s2, b);
            allocate_reg(d);
            issue_alu(op, s1, s2, d);
            await_result(d, alu_expect(op, a, b));
        end
    endtask

    // Three random cases, then divu and remu by the hard zero register.
    task automatic run_mul_div();
        cpu_types_pkg::phys_reg_t s1;
        cpu_types_pkg::phys_reg_t s2;
        cpu_types_pkg::phys_reg_t d;
        cpu_types_pkg::data_t a;
        cpu_types_pkg::data_t b;
        exec_pkg::md_op_e op;
        for (int k = 0; k < 5; k++) begin
            op = (k < 3) ? exec_pkg::md_op_e'(k) : exec_pkg::md_op_e'(k - 2);
            a = $urandom();
            b = (k == 0) ? $urandom() : ($urandom() & 32'h0000_ffff) + 32'd1;
            load_value(s1, a);
            if (k < 3) begin
                load_value(s2, b);
            end else begin
                s2 = '0;
                b = '0;
            end
            allocate_reg(d);
            issue_md(op, s1, s2, d);
            await_result(d, md_expect(op, a, b));
        end
    endtask

    task automatic run_contention();
        cpu_types_pkg::phys_reg_t s1;
        cpu_types_pkg::phys_reg_t s2;
        cpu_types_pkg::phys_reg_t d_pre;
        cpu_types_pkg::phys_reg_t d_alu;
        cpu_types_pkg::phys_reg_t d_md;
        cpu_types_pkg::phys_reg_t d_ld;
        cpu_types_pkg::data_t a;
        cpu_types_pkg::data_t b;
        cpu_types_pkg::data_t ld_val;
        int start_contended;
        a = $urandom();
        b = $urandom();
        ld_val = $urandom();
        load_value(s1, a);
        load_value(s2, b);
        // A lone ALU write first, so the pointer no longer starts at the ALU.
        allocate_reg(d_pre);
        issue_alu(exec_pkg::alu_add, s1, s2, d_pre);
        await_result(d_pre, alu_expect(exec_pkg::alu_add, a, b));
        allocate_reg(d_alu);
        allocate_reg(d_md);
        allocate_reg(d_ld);
        start_contended = contended_cycles;
        // Multiply first so that all three requests line up in one cycle.
        issue_md(exec_pkg::md_mul, s1, s2, d_md);
        issue_alu(exec_pkg::alu_xor, s1, s2, d_alu);
        present_load(d_ld, ld_val);
        finish_load();
        await_result(d_ld, ld_val);
        await_result(d_md, md_expect(exec_pkg::md_mul, a, b));
        await_result(d_alu, alu_expect(exec_pkg::alu_xor, a, b));
        if (contended_cycles - start_contended < 2) begin
            $display("Results did not overlap on the writeback bus.");
            other_errors++;
        end
        if (write_count[d_alu] != 1 || write_count[d_md] != 1 || write_count[d_ld] != 1) begin
            $display("A contended result was not written exactly once.");
            other_errors++;
        end
    endtask

    task automatic check_zero_and_priority();
        cpu_types_pkg::phys_reg_t r;
        cpu_types_pkg::data_t d;
        d = $urandom() | 32'h1;
        present_load('0, d);
        finish_load();
        read_and_compare('0); // Still zero and ready.
        allocate_reg(r);
        @(posedge clk);
        load_result <= '{valid: 1'b1, dst: r, data: d};
        alloc_dst <= r;
        @(negedge clk);
        if (!load_grant) begin
            $display("Load to register %0d was not granted at once.", r);
            other_errors++;
        end
        @(posedge clk);
        load_result <= '0;
        alloc_dst <= '0;
        exp_val[r] = d;
        exp_valid[r] = 1'b0; // Allocation wins.
        read_and_compare(r);
    endtask

    initial begin
        int cycles;
        void'($urandom(87));
        alloc_dst = '0;
        disp_src1 = '0;
        disp_src2 = '0;
        alu_issue = '0;
        md_issue = '0;
        load_result = '0;
        value_errors = 0;
        other_errors = 0;
        contended_cycles = 0;
        next_reg = 64;
        for (int i = 0; i < cpu_types_pkg::num_phys_regs; i++) begin
            exp_val[i] = (i < cpu_types_pkg::num_arch_regs) ? i : 0;
            exp_valid[i] = 1'b1;
            write_count[i] = 0;
        end
        cycles = 0;
        @(posedge clk);
        while (reset && cycles < wait_limit) begin
            @(posedge clk);
            cycles++;
        end
        if (reset) begin
            $display("Reset was never released.");
            other_errors++;
        end
        check_reset_contents();
        run_alu_ops();
        run_mul_div();
        run_contention();
        check_zero_and_priority();
        $display("Errors: %0d value mismatches, %0d other failures.", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period.
    end

    // Synchronous reset held for four rising edges.
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== design/prf_exec_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module prf_exec_top (
    input wire clk,
    input wire reset,
    input wire cpu_types_pkg::phys_reg_t alloc_dst,
    input wire cpu_types_pkg::phys_reg_t disp_src1,
    input wire cpu_types_pkg::phys_reg_t disp_src2,
    output cpu_types_pkg::data_t disp_data1,
    output cpu_types_pkg::data_t disp_data2,
    output logic disp_ready1,
    output logic disp_ready2,
    input wire exec_pkg::alu_issue_t alu_issue,
    output logic alu_busy,
    input wire exec_pkg::md_issue_t md_issue,
    output logic md_busy,
    input wire exec_pkg::wb_result_t load_result,
    output logic load_grant
);

    cpu_types_pkg::phys_reg_t alu_src1;
    cpu_types_pkg::phys_reg_t alu_src2;
    cpu_types_pkg::data_t alu_opnd1;
    cpu_types_pkg::data_t alu_opnd2;
    cpu_types_pkg::phys_reg_t md_src1;
    cpu_types_pkg::phys_reg_t md_src2;
    cpu_types_pkg::data_t md_opnd1;
    cpu_types_pkg::data_t md_opnd2;

    exec_pkg::wb_result_t alu_result;
    exec_pkg::wb_result_t md_result;
    exec_pkg::wb_result_t wb_requests [exec_pkg::num_wb_sources];
    logic [exec_pkg::num_wb_sources-1:0] grant;
    exec_pkg::wb_result_t wb_bus;

    assign wb_requests[exec_pkg::wb_src_alu] = alu_result;
    assign wb_requests[exec_pkg::wb_src_md] = md_result;
    assign wb_requests[exec_pkg::wb_src_load] = load_result;
    assign load_grant = grant[exec_pkg::wb_src_load];

    physical_register_file prf_i (
        .clk(clk), .reset(reset),
        .alloc_dst(alloc_dst),
        .disp_src1(disp_src1), .disp_src2(disp_src2),
        .disp_data1(disp_data1), .disp_data2(disp_data2),
        .disp_ready1(disp_ready1), .disp_ready2(disp_ready2),
        .wb_bus(wb_bus),
        .alu_src1(alu_src1), .alu_src2(alu_src2),
        .alu_opnd1(alu_opnd1), .alu_opnd2(alu_opnd2),
        .md_src1(md_src1), .md_src2(md_src2),
        .md_opnd1(md_opnd1), .md_opnd2(md_opnd2)
    );

    int_alu_unit alu_i (
        .clk(clk), .reset(reset),
        .alu_issue(alu_issue),
        .opnd_src1(alu_src1), .opnd_src2(alu_src2),
        .opnd1(alu_opnd1), .opnd2(alu_opnd2),
        .alu_busy(alu_busy),
        .result(alu_result),
        .grant(grant[exec_pkg::wb_src_alu])
    );

    mul_div_unit md_i (
        .clk(clk), .reset(reset),
        .md_issue(md_issue),
        .opnd_src1(md_src1), .opnd_src2(md_src2),
        .opnd1(md_opnd1), .opnd2(md_opnd2),
        .md_busy(md_busy),
        .result(md_result),
        .grant(grant[exec_pkg::wb_src_md])
    );

    writeback_arbiter arb_i (
        .clk(clk), .reset(reset),
        .requests(wb_requests),
        .grant(grant),
        .wb_bus(wb_bus)
    );

endmodule

`default_nettype wire

// ==== design/writeback_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module writeback_arbiter (
    input wire clk,
    input wire reset,
    input wire exec_pkg::wb_result_t requests [exec_pkg::num_wb_sources],
    output logic [exec_pkg::num_wb_sources-1:0] grant,
    output exec_pkg::wb_result_t wb_bus
);

    logic [exec_pkg::wb_sel_w-1:0] rr_ptr;
    logic [exec_pkg::wb_sel_w-1:0] win_idx;
    logic [exec_pkg::wb_sel_w-1:0] next_ptr;
    logic [exec_pkg::num_wb_sources-1:0] req_valid;
    logic found;

    always_comb begin
        for (int k = 0; k < exec_pkg::num_wb_sources; k++) begin
            req_valid[k] = requests[k].valid;
        end
    end

    // Search starts at the pointer and wraps.
    always_comb begin
        int idx;
        grant = '0;
        found = 1'b0;
        win_idx = '0;
        for (int k = 0; k < exec_pkg::num_wb_sources; k++) begin
            idx = (int'(rr_ptr) + k) % exec_pkg::num_wb_sources;
            if (!found && req_valid[idx]) begin
                found = 1'b1;
                grant[idx] = 1'b1;
                win_idx = exec_pkg::wb_sel_w'(idx);
            end
        end
    end

    assign next_ptr = (win_idx == exec_pkg::wb_sel_w'(exec_pkg::num_wb_sources - 1)) ?
                      '0 : win_idx + 1'b1;

    assign wb_bus = found ? requests[win_idx] : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            rr_ptr <= '0;
        end else if (found) begin
            rr_ptr <= next_ptr; // Winner drops to lowest priority.
        end
    end

    grant_onehot: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(grant)
    ) else $error("writeback_arbiter: more than one grant.");

    grant_to_valid: assert property (
        @(posedge clk) disable iff (reset)
        (grant & ~req_valid) == '0
    ) else $error("writeback_arbiter: grant without a request.");

endmodule

`default_nettype wire

// ==== design/mul_div_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module mul_div_unit (
    input wire clk,
    input wire reset,
    input wire exec_pkg::md_issue_t md_issue,
    output cpu_types_pkg::phys_reg_t opnd_src1,
    output cpu_types_pkg::phys_reg_t opnd_src2,
    input wire cpu_types_pkg::data_t opnd1,
    input wire cpu_types_pkg::data_t opnd2,
    output logic md_busy,
    output exec_pkg::wb_result_t result,
    input wire grant
);

    typedef enum logic [1:0] {
        st_idle,
        st_mul,
        st_div,
        st_done
    } md_state_e;

    md_state_e state;
    logic [5:0] count;
    logic issue_take;

    exec_pkg::md_op_e op_q;
    cpu_types_pkg::phys_reg_t dst_q;
    cpu_types_pkg::data_t op_a;
    cpu_types_pkg::data_t op_b;
    cpu_types_pkg::data_t pp_lo;
    logic [15:0] pp_hi;
    cpu_types_pkg::data_t prod;
    cpu_types_pkg::data_t quo;
    cpu_types_pkg::data_t rem;
    logic [32:0] shifted;
    logic [32:0] diff;
    cpu_types_pkg::data_t res_data;

    assign opnd_src1 = md_issue.src1;
    assign opnd_src2 = md_issue.src2;

    assign md_busy = (state != st_idle);
    assign issue_take = md_issue.valid && (state == st_idle);

    assign result = '{valid: (state == st_done), dst: dst_q, data: res_data};

    // One restoring step. A zero divisor leaves all ones and the dividend.
    assign shifted = {rem, quo[31]};
    assign diff = shifted - {1'b0, op_b};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            count <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (issue_take) begin
                        state <= (md_issue.op == exec_pkg::md_mul) ? st_mul : st_div;
                        count <= (md_issue.op == exec_pkg::md_mul) ? 6'd2 : 6'd32;
                    end
                end
                st_mul, st_div: begin
                    if (count == '0) begin
                        state <= st_done;
                    end else begin
                        count <= count - 6'd1;
                    end
                end
                st_done: begin
                    if (grant) state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue_take) begin
            op_q <= md_issue.op;
            dst_q <= md_issue.dst;
            op_a <= opnd1;
            op_b <= opnd2;
            quo <= opnd1; // Dividend shifts out as the quotient shifts in.
            rem <= '0;
        end
        // Product split into partials, then a sum, then the result register.
        if (state == st_mul) begin
            pp_lo <= op_a[15:0] * op_b;
            pp_hi <= op_a[31:16] * op_b[15:0];
            prod <= pp_lo + {pp_hi, 16'h0000};
            if (count == '0) res_data <= prod;
        end
        if (state == st_div) begin
            if (count != '0) begin
                if (!diff[32]) begin
                    rem <= diff[31:0];
                    quo <= {quo[30:0], 1'b1};
                end else begin
                    rem <= shifted[31:0];
                    quo <= {quo[30:0], 1'b0};
                end
            end else begin
                res_data <= (op_q == exec_pkg::md_remu) ? rem : quo;
            end
        end
    end

    md_no_issue_when_busy: assert property (
        @(posedge clk) disable iff (reset)
        md_busy |-> !md_issue.valid
    ) else $error("mul_div_unit: issue presented while busy.");

endmodule

`default_nettype wire

// ==== design/int_alu_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module int_alu_unit (
    input wire clk,
    input wire reset,
    input wire exec_pkg::alu_issue_t alu_issue,
    output cpu_types_pkg::phys_reg_t opnd_src1,
    output cpu_types_pkg::phys_reg_t opnd_src2,
    input wire cpu_types_pkg::data_t opnd1,
    input wire cpu_types_pkg::data_t opnd2,
    output logic alu_busy,
    output exec_pkg::wb_result_t result,
    input wire grant
);

    logic stage_valid;
    exec_pkg::alu_op_e stage_op;
    cpu_types_pkg::data_t stage_a;
    cpu_types_pkg::data_t stage_b;
    cpu_types_pkg::phys_reg_t stage_dst;
    cpu_types_pkg::data_t alu_out;
    logic issue_take;
    logic stage_move;

    assign opnd_src1 = alu_issue.src1;
    assign opnd_src2 = alu_issue.src2;

    assign alu_busy = result.valid; // Held until the arbiter takes it.
    assign issue_take = alu_issue.valid && !alu_busy;
    assign stage_move = stage_valid && (!result.valid || grant);

    always_comb begin
        case (stage_op)
            exec_pkg::alu_add: alu_out = stage_a + stage_b;
            exec_pkg::alu_sub: alu_out = stage_a - stage_b;
            exec_pkg::alu_and: alu_out = stage_a & stage_b;
            exec_pkg::alu_or:  alu_out = stage_a | stage_b;
            exec_pkg::alu_xor: alu_out = stage_a ^ stage_b;
            exec_pkg::alu_slt: alu_out = cpu_types_pkg::data_t'($signed(stage_a) < $signed(stage_b));
            default:           alu_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= 1'b0;
        end else if (issue_take) begin
            stage_valid <= 1'b1;
        end else if (stage_move) begin
            stage_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_take) begin
            stage_op <= alu_issue.op;
            stage_a <= opnd1;
            stage_b <= opnd2;
            stage_dst <= alu_issue.dst;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result.valid <= 1'b0;
        end else if (stage_move) begin
            result.valid <= 1'b1;
            result.dst <= stage_dst;
            result.data <= alu_out;
        end else if (grant) begin
            result.valid <= 1'b0;
        end
    end

    alu_no_issue_when_busy: assert property (
        @(posedge clk) disable iff (reset)
        alu_busy |-> !alu_issue.valid
    ) else $error("int_alu_unit: issue presented while busy.");

endmodule

`default_nettype wire

// ==== design/physical_register_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module physical_register_file (
    input wire clk,
    input wire reset,

    // Rename side.
    input wire cpu_types_pkg::phys_reg_t alloc_dst,
    input wire cpu_types_pkg::phys_reg_t disp_src1,
    input wire cpu_types_pkg::phys_reg_t disp_src2,
    output cpu_types_pkg::data_t disp_data1,
    output cpu_types_pkg::data_t disp_data2,
    output logic disp_ready1,
    output logic disp_ready2,

    // Shared result bus.
    input wire exec_pkg::wb_result_t wb_bus,

    // Operand reads at issue.
    input wire cpu_types_pkg::phys_reg_t alu_src1,
    input wire cpu_types_pkg::phys_reg_t alu_src2,
    output cpu_types_pkg::data_t alu_opnd1,
    output cpu_types_pkg::data_t alu_opnd2,
    input wire cpu_types_pkg::phys_reg_t md_src1,
    input wire cpu_types_pkg::phys_reg_t md_src2,
    output cpu_types_pkg::data_t md_opnd1,
    output cpu_types_pkg::data_t md_opnd2
);

    cpu_types_pkg::data_t regs [cpu_types_pkg::num_phys_regs];
    logic [cpu_types_pkg::num_phys_regs-1:0] reg_valid;

    logic wb_write;
    logic alloc_clear;

    assign wb_write = wb_bus.valid && (wb_bus.dst != '0);
    assign alloc_clear = (alloc_dst != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < cpu_types_pkg::num_phys_regs; i++) begin
                regs[i] <= (i < cpu_types_pkg::num_arch_regs) ? cpu_types_pkg::data_t'(i) : '0;
            end
            reg_valid <= '1;
        end else begin
            if (wb_write) begin
                regs[wb_bus.dst] <= wb_bus.data;
                reg_valid[wb_bus.dst] <= 1'b1;
            end
            // Allocation comes last so it wins over a write to the same register.
            if (alloc_clear) begin
                reg_valid[alloc_dst] <= 1'b0;
            end
        end
    end

    // Plain reads, no bypass from the bus.
    assign disp_data1 = regs[disp_src1];
    assign disp_data2 = regs[disp_src2];
    assign disp_ready1 = reg_valid[disp_src1];
    assign disp_ready2 = reg_valid[disp_src2];

    assign alu_opnd1 = regs[alu_src1];
    assign alu_opnd2 = regs[alu_src2];

    assign md_opnd1 = regs[md_src1];
    assign md_opnd2 = regs[md_src2];

    // A producer may only write a register that rename has allocated.
    write_to_allocated: assert property (
        @(posedge clk) disable iff (reset)
        wb_write |-> !reg_valid[wb_bus.dst]
    ) else $error("physical_register_file: write to unallocated register %0d.", wb_bus.dst);

endmodule

`default_nettype wire

// ==== design/exec_pkg.sv ====
`default_nettype none

// Execution side: opcodes, issue packets and writeback results.
package exec_pkg;

    localparam int num_wb_sources = 3;
    localparam int wb_sel_w = $clog2(num_wb_sources);

    // Source order on the writeback arbiter.
    localparam int wb_src_alu = 0;
    localparam int wb_src_md = 1;
    localparam int wb_src_load = 2;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt // Signed compare.
    } alu_op_e;

    typedef enum logic [1:0] {
        md_mul, // Low 32 bits of the product.
        md_divu,
        md_remu
    } md_op_e;

    typedef struct packed {
        logic valid;
        alu_op_e op;
        cpu_types_pkg::phys_reg_t src1;
        cpu_types_pkg::phys_reg_t src2;
        cpu_types_pkg::phys_reg_t dst;
    } alu_issue_t;

    typedef struct packed {
        logic valid;
        md_op_e op;
        cpu_types_pkg::phys_reg_t src1;
        cpu_types_pkg::phys_reg_t src2;
        cpu_types_pkg::phys_reg_t dst;
    } md_issue_t;

    typedef struct packed {
        logic valid;
        cpu_types_pkg::phys_reg_t dst;
        cpu_types_pkg::data_t data;
    } wb_result_t;

endpackage

`default_nettype wire

// ==== design/cpu_types_pkg.sv ====
`default_nettype none

// Geometry of the physical register file and the datapath word.
package cpu_types_pkg;

    localparam int num_phys_regs = 256;
    localparam int num_arch_regs = 32; // These come out of reset holding their own index.

    localparam int phys_idx_w = $clog2(num_phys_regs);
    localparam int data_w = 32;

    // Index 0 is the hard zero register.
    typedef logic [phys_idx_w-1:0] phys_reg_t;

    typedef logic [data_w-1:0] data_t;

endpackage

`default_nettype wire
